// File: hack_pkg.sv
package hack_pkg;

    // one machine word, data and instructions alike
    typedef logic [15:0] word_t;

    // instruction word, decoded as either an A or a C instruction
    typedef union packed {
        struct packed {
            logic        is_c;    // 0 for A instruction
            logic [14:0] value;   // constant loaded into A
        } a_instr;
        struct packed {
            logic       is_c;     // 1 for C instruction
            logic [1:0] unused;
            logic       a_sel;    // y operand is M when set, A otherwise
            logic [5:0] comp;     // zx nx zy ny f no
            logic [2:0] dest;     // A D M
            logic [2:0] jump;     // lt eq gt
        } c_instr;
    } hack_instr_t;

    // program store
    localparam int ROM_DEPTH  = 256;
    localparam int ROM_ADDR_W = 8;    // pc wraps modulo ROM_DEPTH

    // data address space
    localparam int ADDR_W     = 15;

    // data ram, 0 .. 16383
    localparam int RAM_WORDS  = 16384;
    localparam int RAM_ADDR_W = 14;

    // screen window, 16384 .. 24575
    localparam int SCREEN_BASE   = 16384;
    localparam int SCREEN_WORDS  = 8192;
    localparam int SCREEN_ADDR_W = 13;

    // keyboard register, read only
    localparam int KBD_ADDR = 24576;

endpackage

// File: hack_alu.sv
module hack_alu (
    input  hack_pkg::word_t x,      // D register
    input  hack_pkg::word_t y,      // A register or M
    input  logic [5:0]      comp,   // zx nx zy ny f no
    output hack_pkg::word_t result,
    output logic            zr,
    output logic            ng
);

    logic zx;
    logic nx;
    logic zy;
    logic ny;
    logic f;
    logic no;

    hack_pkg::word_t x_z;
    hack_pkg::word_t x_n;
    hack_pkg::word_t y_z;
    hack_pkg::word_t y_n;
    hack_pkg::word_t f_out;
    hack_pkg::word_t res;

    assign zx = comp[5];
    assign nx = comp[4];
    assign zy = comp[3];
    assign ny = comp[2];
    assign f  = comp[1];
    assign no = comp[0];

    always_comb begin
        // operand preprocessing, zero first then negate
        x_z = zx ? '0 : x;
        x_n = nx ? ~x_z : x_z;
        y_z = zy ? '0 : y;
        y_n = ny ? ~y_z : y_z;

        if (f) begin
            f_out = x_n + y_n;    // carry out dropped
        end else begin
            f_out = x_n & y_n;
        end

        res = no ? ~f_out : f_out;
    end

    assign result = res;
    assign zr     = (res == '0);
    assign ng     = res[15];      // two's complement sign

endmodule

// File: hack_cpu.sv
module hack_cpu (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              run,
    input  hack_pkg::hack_instr_t             instr,
    output logic [hack_pkg::ROM_ADDR_W-1:0]   pc,
    input  hack_pkg::word_t                   out,      // M, read from data memory
    output hack_pkg::word_t                   in,       // value to store
    output logic [hack_pkg::ADDR_W-1:0]       address,
    output logic                              load
);

    // phase 0 is fetch, phase 1 is execute
    logic exec_phase;

    logic [hack_pkg::ROM_ADDR_W-1:0] pc_reg;
    hack_pkg::word_t                 a_reg;
    hack_pkg::word_t                 d_reg;

    hack_pkg::word_t alu_y;
    hack_pkg::word_t alu_result;
    logic            zr;
    logic            ng;

    logic       is_c;
    logic [2:0] dest;
    logic [2:0] jump;
    logic       take_jump;

    assign is_c = instr.c_instr.is_c;
    assign dest = instr.c_instr.dest;
    assign jump = instr.c_instr.jump;

    // a_sel picks M over A as the second operand
    assign alu_y = instr.c_instr.a_sel ? out : a_reg;

    hack_alu i_alu (
        .x      (d_reg),
        .y      (alu_y),
        .comp   (instr.c_instr.comp),
        .result (alu_result),
        .zr     (zr),
        .ng     (ng)
    );

    // lt, eq, gt against the alu flags
    always_comb begin
        take_jump = 1'b0;
        if (jump[2] && ng) begin
            take_jump = 1'b1;
        end
        if (jump[1] && zr) begin
            take_jump = 1'b1;
        end
        if (jump[0] && !zr && !ng) begin
            take_jump = 1'b1;
        end
    end

    assign pc      = pc_reg;
    assign address = a_reg[hack_pkg::ADDR_W-1:0];   // M is always at A
    assign in      = alu_result;
    assign load    = exec_phase && is_c && dest[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            exec_phase <= 1'b0;
            pc_reg     <= '0;
            a_reg      <= '0;
            d_reg      <= '0;
        end else if (exec_phase) begin
            // an execute always completes, run only gates the next fetch
            exec_phase <= 1'b0;

            if (!is_c) begin
                a_reg <= {1'b0, instr.a_instr.value};
            end else begin
                if (dest[2]) begin
                    a_reg <= alu_result;
                end
                if (dest[1]) begin
                    d_reg <= alu_result;
                end
            end

            // jump target is the A value before this update
            if (is_c && take_jump) begin
                pc_reg <= a_reg[hack_pkg::ROM_ADDR_W-1:0];
            end else begin
                pc_reg <= pc_reg + 1'b1;
            end
        end else if (run) begin
            exec_phase <= 1'b1;   // instr and M arrive next cycle
        end
    end

    // a rom word never loaded would execute as garbage
    a_instr_known : assert property (
        @(posedge clk) disable iff (rst)
        exec_phase |-> !$isunknown(instr)
    );

endmodule

// File: instruction_rom.sv
module instruction_rom (
    input  logic                            clk,
    input  logic                            prog_we,
    input  logic [hack_pkg::ROM_ADDR_W-1:0] prog_address,
    input  hack_pkg::word_t                 prog_data,
    input  logic [hack_pkg::ROM_ADDR_W-1:0] pc,
    output hack_pkg::hack_instr_t           instr
);

    hack_pkg::hack_instr_t mem [hack_pkg::ROM_DEPTH];

    hack_pkg::hack_instr_t instr_q;

    // load port, one word per cycle
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_address] <= hack_pkg::hack_instr_t'(prog_data);
        end
    end

    // synchronous read, instr valid in the execute phase
    always_ff @(posedge clk) begin
        instr_q <= mem[pc];
    end

    assign instr = instr_q;

endmodule

// File: data_memory.sv
module data_memory (
    input  logic                               clk,
    input  hack_pkg::word_t                    in,
    input  logic [hack_pkg::ADDR_W-1:0]        address,
    input  logic                               load,
    input  logic [7:0]                         keyboard,
    output hack_pkg::word_t                    out,
    output logic [hack_pkg::SCREEN_ADDR_W-1:0] screen_address,
    output hack_pkg::word_t                    screen_data,
    output logic                               screen_we
);

    // contents start at zero and survive reset
    hack_pkg::word_t ram    [hack_pkg::RAM_WORDS]    = '{default: '0};
    hack_pkg::word_t shadow [hack_pkg::SCREEN_WORDS] = '{default: '0};   // screen read-back copy

    logic is_ram;
    logic is_screen;
    logic is_kbd;
    logic ram_we;
    logic shadow_we;

    logic [hack_pkg::RAM_ADDR_W-1:0]    ram_idx;
    logic [hack_pkg::SCREEN_ADDR_W-1:0] scr_idx;

    hack_pkg::word_t                    out_q;
    logic                               screen_we_q = 1'b0;
    logic [hack_pkg::SCREEN_ADDR_W-1:0] screen_address_q;
    hack_pkg::word_t                    screen_data_q;

    // address map
    assign is_ram    = (address < hack_pkg::SCREEN_BASE);
    assign is_screen = (address >= hack_pkg::SCREEN_BASE) &&
                       (address < hack_pkg::SCREEN_BASE + hack_pkg::SCREEN_WORDS);
    assign is_kbd    = (address == hack_pkg::KBD_ADDR);

    assign ram_idx   = address[hack_pkg::RAM_ADDR_W-1:0];
    assign scr_idx   = address[hack_pkg::SCREEN_ADDR_W-1:0];   // offset in the window

    assign ram_we    = load && is_ram;
    assign shadow_we = load && is_screen;   // keyboard and unmapped drop the write

    always_ff @(posedge clk) begin
        if (ram_we) begin
            ram[ram_idx] <= in;
        end
        if (shadow_we) begin
            shadow[scr_idx] <= in;
        end
    end

    // registered read mux, old data on a same-cycle write
    always_ff @(posedge clk) begin
        if (is_ram) begin
            out_q <= ram[ram_idx];
        end else if (is_screen) begin
            out_q <= shadow[scr_idx];
        end else if (is_kbd) begin
            out_q <= {8'h00, keyboard};
        end else begin
            out_q <= '0;
        end
    end

    // screen write leaves one cycle after the store
    always_ff @(posedge clk) begin
        screen_we_q      <= shadow_we;
        screen_address_q <= scr_idx;
        screen_data_q    <= in;
    end

    assign out            = out_q;
    assign screen_we      = screen_we_q;
    assign screen_address = screen_address_q;
    assign screen_data    = screen_data_q;

    // the strobe of one store never overlaps the next ram store
    a_ram_screen_exclusive : assert property (
        @(posedge clk) !(ram_we && screen_we)
    );

endmodule

// File: screen_buffer.sv
module screen_buffer (
    input  logic                               clk,
    input  logic [hack_pkg::SCREEN_ADDR_W-1:0] screen_address,
    input  hack_pkg::word_t                    screen_data,
    input  logic                               screen_we,
    input  logic [hack_pkg::SCREEN_ADDR_W-1:0] pixel_address,
    output hack_pkg::word_t                    pixel_data
);

    // one word per 16 pixels, blank at start
    hack_pkg::word_t mem [hack_pkg::SCREEN_WORDS] = '{default: '0};

    hack_pkg::word_t pixel_q;

    // cpu side
    always_ff @(posedge clk) begin
        if (screen_we) begin
            mem[screen_address] <= screen_data;
        end
    end

    // display fetch side
    always_ff @(posedge clk) begin
        pixel_q <= mem[pixel_address];
    end

    assign pixel_data = pixel_q;

    // a strobe with an unknown address would corrupt an unknown word
    a_addr_known : assert property (
        @(posedge clk) screen_we |-> !$isunknown(screen_address)
    );

endmodule

// File: hack_computer.sv
module hack_computer (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               run,
    input  logic                               prog_we,
    input  logic [hack_pkg::ROM_ADDR_W-1:0]    prog_address,
    input  hack_pkg::word_t                    prog_data,
    input  logic [7:0]                         keyboard,
    input  logic [hack_pkg::SCREEN_ADDR_W-1:0] pixel_address,
    output hack_pkg::word_t                    pixel_data,
    output logic                               screen_we,
    output logic [hack_pkg::SCREEN_ADDR_W-1:0] screen_address,
    output hack_pkg::word_t                    screen_data
);

    logic [hack_pkg::ROM_ADDR_W-1:0] pc;
    hack_pkg::hack_instr_t           instr;

    hack_pkg::word_t                 mem_out;    // M back to the cpu
    hack_pkg::word_t                 mem_in;
    logic [hack_pkg::ADDR_W-1:0]     mem_address;
    logic                            mem_load;

    instruction_rom i_rom (
        .clk          (clk),
        .prog_we      (prog_we),
        .prog_address (prog_address),
        .prog_data    (prog_data),
        .pc           (pc),
        .instr        (instr)
    );

    hack_cpu i_cpu (
        .clk     (clk),
        .rst     (rst),
        .run     (run),
        .instr   (instr),
        .pc      (pc),
        .out     (mem_out),
        .in      (mem_in),
        .address (mem_address),
        .load    (mem_load)
    );

    data_memory i_mem (
        .clk            (clk),
        .in             (mem_in),
        .address        (mem_address),
        .load           (mem_load),
        .keyboard       (keyboard),
        .out            (mem_out),
        .screen_address (screen_address),
        .screen_data    (screen_data),
        .screen_we      (screen_we)
    );

    screen_buffer i_screen (
        .clk            (clk),
        .screen_address (screen_address),
        .screen_data    (screen_data),
        .screen_we      (screen_we),
        .pixel_address  (pixel_address),
        .pixel_data     (pixel_data)
    );

endmodule

// File: tb_checker.sv
module tb_checker (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               prog_we,
    input  logic [hack_pkg::ROM_ADDR_W-1:0]    prog_address,
    input  hack_pkg::word_t                    prog_data,
    input  logic                               start,
    input  int                                 n_steps,
    input  logic [7:0]                         keyboard,
    input  int                                 test_id,
    input  logic                               screen_we,
    input  logic [hack_pkg::SCREEN_ADDR_W-1:0] screen_address,
    input  hack_pkg::word_t                    screen_data,
    input  logic                               dumping,
    input  logic [hack_pkg::SCREEN_ADDR_W-1:0] pixel_address,
    input  hack_pkg::word_t                    pixel_data,
    output int                                 write_errs,
    output int                                 dump_errs,
    output int                                 other_errs
);

    // model machine state, ram and screen survive reset
    hack_pkg::word_t m_rom [hack_pkg::ROM_DEPTH];
    hack_pkg::word_t m_ram [hack_pkg::RAM_WORDS];
    hack_pkg::word_t m_scr [hack_pkg::SCREEN_WORDS];
    hack_pkg::word_t m_a;
    hack_pkg::word_t m_d;
    logic [7:0]      m_pc;
    logic [7:0]      m_kbd;

    logic [hack_pkg::SCREEN_ADDR_W-1:0] exp_addr [$];
    hack_pkg::word_t                    exp_data [$];
    logic [hack_pkg::SCREEN_ADDR_W-1:0] e_addr;
    hack_pkg::word_t                    e_data;
    logic [hack_pkg::SCREEN_ADDR_W-1:0] pix_q;
    logic                               dump_q;

    initial begin
        for (int i = 0; i < hack_pkg::RAM_WORDS; i++) begin
            m_ram[i] = '0;
        end
        for (int i = 0; i < hack_pkg::SCREEN_WORDS; i++) begin
            m_scr[i] = '0;
        end
        write_errs = 0;
        dump_errs  = 0;
        other_errs = 0;
        dump_q     = 1'b0;
        pix_q      = '0;
    end

    function automatic string name_of(int id);
        case (id)
            0: return "reset_idle";
            1: return "alu_ops";
            2: return "jumps";
            3: return "address_map";
            default: return "random_programs";
        endcase
    endfunction

    // zx nx zy ny f no, applied in order
    function automatic hack_pkg::word_t alu_ref(hack_pkg::word_t x, hack_pkg::word_t y,
                                                logic [5:0] c);
        hack_pkg::word_t r;
        if (c[5]) x = '0;
        if (c[4]) x = ~x;
        if (c[3]) y = '0;
        if (c[2]) y = ~y;
        r = c[1] ? x + y : x & y;
        if (c[0]) r = ~r;
        return r;
    endfunction

    function automatic hack_pkg::word_t read_ref(logic [14:0] addr);
        if (addr < hack_pkg::SCREEN_BASE) return m_ram[addr[13:0]];
        if (addr < hack_pkg::KBD_ADDR) return m_scr[13'(addr - hack_pkg::SCREEN_BASE)];
        if (addr == hack_pkg::KBD_ADDR) return {8'h00, m_kbd};
        return '0;    // unmapped
    endfunction

    function automatic void write_ref(logic [14:0] addr, hack_pkg::word_t v);
        logic [12:0] idx;
        idx = 13'(addr - hack_pkg::SCREEN_BASE);
        if (addr < hack_pkg::SCREEN_BASE) begin
            m_ram[addr[13:0]] = v;
        end else if (addr < hack_pkg::KBD_ADDR) begin
            m_scr[idx] = v;
            exp_addr.push_back(idx);
            exp_data.push_back(v);
        end
    endfunction

    // one instruction of the reference machine
    function automatic void step_ref();
        hack_pkg::hack_instr_t ins;
        hack_pkg::word_t       r;
        logic                  jmp;
        logic [7:0]            next_pc;
        ins = hack_pkg::hack_instr_t'(m_rom[m_pc]);
        if (!ins.a_instr.is_c) begin
            m_a  = {1'b0, ins.a_instr.value};
            m_pc = m_pc + 8'd1;
            return;
        end
        r = alu_ref(m_d, ins.c_instr.a_sel ? read_ref(m_a[14:0]) : m_a, ins.c_instr.comp);
        jmp = (ins.c_instr.jump[2] && r[15]) || (ins.c_instr.jump[1] && r == '0) ||
              (ins.c_instr.jump[0] && r != '0 && !r[15]);
        next_pc = jmp ? m_a[7:0] : m_pc + 8'd1;    // target is the old A
        if (ins.c_instr.dest[0]) write_ref(m_a[14:0], r);
        if (ins.c_instr.dest[2]) m_a = r;
        if (ins.c_instr.dest[1]) m_d = r;
        m_pc = next_pc;
    endfunction

    always @(negedge clk) begin
        if (prog_we) begin
            m_rom[prog_address] = prog_data;
        end
        if (rst && screen_we) begin
            $display("Screen write strobe raised during reset in %s", name_of(test_id));
            other_errs = other_errs + 1;
        end
        if (screen_we) begin
            if (exp_addr.size() == 0) begin
                $display("Unexpected screen write to word %0d in %s",
                         screen_address, name_of(test_id));
                other_errs = other_errs + 1;
            end else begin
                e_addr = exp_addr.pop_front();
                e_data = exp_data.pop_front();
                if (e_addr !== screen_address || e_data !== screen_data) begin
                    $display("Error %s: screen write expected %0d/%h actual %0d/%h",
                             name_of(test_id), e_addr, e_data, screen_address, screen_data);
                    write_errs = write_errs + 1;
                end
            end
        end
        if (start) begin
            m_a   = '0;    // cpu registers clear on reset
            m_d   = '0;
            m_pc  = '0;
            m_kbd = keyboard;
            for (int i = 0; i < n_steps; i++) begin
                step_ref();
            end
        end
        // pixel_data now holds the word addressed one cycle earlier
        if (dump_q && pixel_data !== m_scr[pix_q]) begin
            $display("Error %s: screen word %0d expected %h actual %h",
                     name_of(test_id), pix_q, m_scr[pix_q], pixel_data);
            dump_errs = dump_errs + 1;
        end
        if (dumping && !dump_q && exp_addr.size() != 0) begin
            $display("%0d expected screen writes never appeared in %s",
                     exp_addr.size(), name_of(test_id));
            other_errs = other_errs + 1;
            exp_addr.delete();
            exp_data.delete();
        end
        dump_q = dumping;
        pix_q  = pixel_address;
    end

endmodule

// File: tb_hack.sv
module tb_hack;

    localparam int CLK_PERIOD   = 40;
    localparam int ALU_N        = 72;     // 18 ops of 4 instructions
    localparam int JMP_N        = 192;    // 24 cases of 8 instructions
    localparam int MAP_N        = 32;
    localparam int RND_N        = 300;
    localparam int RUN_COUNT    = 8;
    localparam int STEP_TOTAL   = ALU_N + JMP_N + 2 * MAP_N + 3 * RND_N;
    localparam int LIMIT_CYCLES = RUN_COUNT * (256 + 8192 + 10) + 2 * STEP_TOTAL + 200;

    logic                               clk;
    logic                               rst;
    logic                               run;
    logic                               prog_we;
    logic [hack_pkg::ROM_ADDR_W-1:0]    prog_address;
    hack_pkg::word_t                    prog_data;
    logic [7:0]                         keyboard;
    logic [hack_pkg::SCREEN_ADDR_W-1:0] pixel_address;
    hack_pkg::word_t                    pixel_data;
    logic                               screen_we;
    logic [hack_pkg::SCREEN_ADDR_W-1:0] screen_address;
    hack_pkg::word_t                    screen_data;

    logic start;      // one cycle at run start
    logic dumping;    // screen read-out in progress
    int   n_steps;
    int   test_id;
    int   write_errs;
    int   dump_errs;
    int   other_errs;

    hack_pkg::word_t prog [hack_pkg::ROM_DEPTH];
    int              wp;

    // the 18 hack computations
    logic [5:0] alu_codes [18] = '{
        6'b101010, 6'b111111, 6'b111010, 6'b001100, 6'b110000, 6'b001101,
        6'b110001, 6'b001111, 6'b110011, 6'b011111, 6'b110111, 6'b001110,
        6'b110010, 6'b000010, 6'b010011, 6'b000111, 6'b000000, 6'b010101
    };

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    hack_computer i_dut (
        .clk            (clk),
        .rst            (rst),
        .run            (run),
        .prog_we        (prog_we),
        .prog_address   (prog_address),
        .prog_data      (prog_data),
        .keyboard       (keyboard),
        .pixel_address  (pixel_address),
        .pixel_data     (pixel_data),
        .screen_we      (screen_we),
        .screen_address (screen_address),
        .screen_data    (screen_data)
    );

    tb_checker i_check (
        .clk            (clk),
        .rst            (rst),
        .prog_we        (prog_we),
        .prog_address   (prog_address),
        .prog_data      (prog_data),
        .start          (start),
        .n_steps        (n_steps),
        .keyboard       (keyboard),
        .test_id        (test_id),
        .screen_we      (screen_we),
        .screen_address (screen_address),
        .screen_data    (screen_data),
        .dumping        (dumping),
        .pixel_address  (pixel_address),
        .pixel_data     (pixel_data),
        .write_errs     (write_errs),
        .dump_errs      (dump_errs),
        .other_errs     (other_errs)
    );

    function automatic hack_pkg::word_t a_ins(int unsigned value);
        return {1'b0, value[14:0]};
    endfunction

    function automatic hack_pkg::word_t c_ins(logic a_sel, logic [5:0] comp,
                                              logic [2:0] dest, logic [2:0] jump);
        return {3'b111, a_sel, comp, dest, jump};
    endfunction

    task automatic emit(hack_pkg::word_t w);
        prog[wp] = w;
        wp = wp + 1;
    endtask

    task automatic clear_prog();
        for (int i = 0; i < hack_pkg::ROM_DEPTH; i++) begin
            prog[i] = a_ins(0);    // padding runs as harmless @0
        end
        wp = 0;
    endtask

    task automatic emit_store(int unsigned addr);
        emit(a_ins(addr));
        emit(c_ins(1'b0, 6'b001100, 3'b001, 3'b000));    // M=D
    endtask

    task automatic emit_fetch(int unsigned addr);
        emit(a_ins(addr));
        emit(c_ins(1'b1, 6'b110000, 3'b010, 3'b000));    // D=M
    endtask

    task automatic gen_alu();
        clear_prog();
        for (int k = 0; k < 18; k++) begin
            emit(a_ins(1 + $urandom % 32767));
            emit(c_ins(1'b0, (k % 2 == 1) ? 6'b110011 : 6'b110000, 3'b010, 3'b000));
            emit(a_ins(hack_pkg::SCREEN_BASE + k));
            emit(c_ins(1'b0, alu_codes[k], 3'b001, 3'b000));
        end
    endtask

    task automatic gen_jumps();
        int base;
        int idx;
        clear_prog();
        for (int j = 0; j < 8; j++) begin
            for (int v = 0; v < 3; v++) begin
                base = wp;
                idx  = j * 3 + v;
                emit(a_ins(1 + $urandom % 32767));
                // D becomes zero, negative or positive
                emit(c_ins(1'b0, (v == 0) ? 6'b101010 : (v == 1) ? 6'b110011 : 6'b110000,
                           3'b010, 3'b000));
                emit(a_ins(base + 6));
                emit(c_ins(1'b0, 6'b001100, 3'b000, 3'(j)));
                emit(a_ins(hack_pkg::SCREEN_BASE + 32 + idx));
                emit(c_ins(1'b0, 6'b111111, 3'b001, 3'b000));    // skipped marker
                emit_store(hack_pkg::SCREEN_BASE + 64 + idx);    // landing marker
            end
        end
    endtask

    task automatic gen_map();
        clear_prog();
        emit(a_ins(1 + $urandom % 32767));
        emit(c_ins(1'b0, 6'b110000, 3'b010, 3'b000));
        emit_store(100);
        emit_fetch(100);
        emit_store(hack_pkg::SCREEN_BASE + 200);
        emit_fetch(hack_pkg::KBD_ADDR);
        emit_store(hack_pkg::SCREEN_BASE + 201);
        emit_store(hack_pkg::SCREEN_BASE + hack_pkg::SCREEN_WORDS - 1);   // last screen word
        emit(a_ins(7));
        emit(c_ins(1'b0, 6'b110000, 3'b010, 3'b000));
        emit_store(hack_pkg::KBD_ADDR);
        emit_store(30000);
        emit_fetch(30000);
        emit_store(hack_pkg::SCREEN_BASE + 202);
        emit_fetch(hack_pkg::KBD_ADDR);
        emit_store(hack_pkg::SCREEN_BASE + 203);
    endtask

    task automatic gen_random();
        int unsigned r;
        logic [2:0]  dest;
        logic [2:0]  jump;
        clear_prog();
        for (int i = 0; i < hack_pkg::ROM_DEPTH; i++) begin
            r = $urandom % 10;
            if ($urandom % 2 == 0) begin
                if (r < 6) begin
                    emit(a_ins(hack_pkg::SCREEN_BASE + $urandom % hack_pkg::SCREEN_WORDS));
                end else if (r < 8) begin
                    emit(a_ins($urandom % hack_pkg::ROM_DEPTH));   // jump target
                end else begin
                    emit(a_ins($urandom));
                end
            end else begin
                dest = 3'($urandom % 8);
                dest[0] = dest[0] | (r < 6);    // favour M stores
                jump = ($urandom % 10 < 3) ? 3'($urandom % 8) : 3'b000;
                emit(c_ins(1'($urandom % 2), 6'($urandom % 64), dest, jump));
            end
        end
    endtask

    task automatic load_prog();
        for (int i = 0; i < hack_pkg::ROM_DEPTH; i++) begin
            @(posedge clk);
            prog_we      <= 1'b1;
            prog_address <= 8'(i);
            prog_data    <= prog[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    // load, reset, run n instructions, then read the whole screen back
    task automatic run_test(int id, int n, logic [7:0] kbd);
        load_prog();
        @(posedge clk);
        keyboard <= kbd;
        test_id  <= id;
        rst      <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        run     <= (n > 0);
        start   <= 1'b1;
        n_steps <= n;
        @(posedge clk);
        start <= 1'b0;
        if (n > 0) begin
            repeat (2 * n - 1) @(posedge clk);
        end
        run <= 1'b0;
        repeat (3) @(posedge clk);    // last screen write lands
        for (int i = 0; i < hack_pkg::SCREEN_WORDS; i++) begin
            @(posedge clk);
            dumping       <= 1'b1;
            pixel_address <= 13'(i);
        end
        @(posedge clk);
        dumping <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    initial begin
        rst           = 1'b1;
        run           = 1'b0;
        prog_we       = 1'b0;
        prog_address  = '0;
        prog_data     = '0;
        keyboard      = '0;
        pixel_address = '0;
        start         = 1'b0;
        dumping       = 1'b0;
        n_steps       = 0;
        test_id       = 0;
        void'($urandom(32'hd7d74ed3));
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        gen_random();
        run_test(0, 0, 8'($urandom));
        gen_alu();
        run_test(1, ALU_N, 8'h00);
        gen_jumps();
        run_test(2, JMP_N, 8'h00);
        gen_map();
        run_test(3, MAP_N, 8'h5a);
        run_test(3, MAP_N, 8'hc3);
        repeat (3) begin
            gen_random();
            run_test(4, RND_N, 8'($urandom));
        end

        @(posedge clk);
        $display("Errors: %0d screen write, %0d dump, %0d other",
                 write_errs, dump_errs, other_errs);
        if (write_errs + dump_errs + other_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("Timeout: simulation did not finish within %0d cycles", LIMIT_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

// File: tb.f
hack_pkg.sv
hack_alu.sv
hack_cpu.sv
instruction_rom.sv
data_memory.sv
screen_buffer.sv
hack_computer.sv
tb_checker.sv
tb_hack.sv
